//--- Bender.yml
package:
  name: hist_scope

export_include_dirs:
  - .

sources:
  - hist_pkg.sv
  - hist_frame_seq.sv
  - hist_column_painter.sv
  - hist_mem_arbiter.sv
  - hist_scope_top.sv
  - target: test
    files:
      - hist_scope_props.sv
      - tb_hist_scope.sv

//--- hist_column_painter.sv
`include "hist_settings.svh"

module hist_column_painter (
    input  logic                   clk,
    input  logic                   rst_n,
    // From the sequencer.
    input  logic                   job_valid,
    input  hist_pkg::column_job_t  job,
    output logic                   job_done,
    // Write side.
    output logic                   wr_req,
    output hist_pkg::mem_wr_t      wr_cmd,
    input  logic                   wr_done
);

    typedef enum logic [1:0] {
        P_IDLE, // Wait for a column job.
        P_WR,   // One pixel per handshake.
        P_DONE  // job_done cycle.
    } state_t;

    state_t                   state_q;
    logic [7:0]               p_q;   // Pixel offset above baseline.
    logic [`HIST_ADDR_W-1:0]  row_q; // Row start of the job.
    logic [7:0]               h_q;   // Bar height of the job.

    ////////////////////////////////////////////////////////////////////////////
    // Pixel command.
    ////////////////////////////////////////////////////////////////////////////

    // Walk runs from the top of the plot down to the baseline.
    // Everything above the bar is repainted with background,
    // which wipes the previous bar of this column.
    assign wr_cmd.addr = row_q + `HIST_ADDR_W'(`HIST_PLOT_X0) + `HIST_ADDR_W'(p_q);
    assign wr_cmd.data = (p_q > h_q) ? `COLOR_BACKGROUND : `COLOR_BAR;

    ////////////////////////////////////////////////////////////////////////////
    // Painter FSM.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= P_IDLE;
            p_q      <= '0;
            wr_req   <= 1'b0;
            job_done <= 1'b0;
        end else begin
            case (state_q)
                P_IDLE: begin
                    if (job_valid) begin
                        p_q     <= 8'(`HIST_PLOT_H); // Topmost pixel first.
                        wr_req  <= 1'b1;
                        state_q <= P_WR;
                    end
                end
                P_WR: begin
                    if (wr_done) begin
                        wr_req <= 1'b0; // Req drops for a cycle between pixels.
                        if (p_q == '0) begin
                            job_done <= 1'b1; // Baseline written.
                            state_q  <= P_DONE;
                        end else begin
                            p_q <= p_q - 1'b1;
                        end
                    end else begin
                        wr_req <= 1'b1;
                    end
                end
                P_DONE: begin
                    // Sequencer drops job_valid now, so idle
                    // never sees the finished job again.
                    job_done <= 1'b0;
                    state_q  <= P_IDLE;
                end
                default: state_q <= P_IDLE;
            endcase
        end
    end

    // Job fields captured at accept time.
    always_ff @(posedge clk) begin
        if (state_q == P_IDLE && job_valid) begin
            row_q <= job.row_addr;
            h_q   <= job.height;
        end
    end

endmodule

//--- hist_frame_seq.sv
`include "hist_settings.svh"

module hist_frame_seq (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     en,
    // Pulse counter.
    input  logic                     sample_valid,
    input  logic [`HIST_DATA_W-1:0]  sample_count,
    // Write side.
    output logic                     wr_req,
    output hist_pkg::mem_wr_t        wr_cmd,
    input  logic                     wr_done,
    // Read side.
    output logic                     rd_req,
    output hist_pkg::mem_rd_t        rd_cmd,
    input  logic                     rd_done,
    input  logic [`HIST_DATA_W-1:0]  rd_data,
    // Column painter.
    output logic                     job_valid,
    output hist_pkg::column_job_t    job,
    input  logic                     job_done,
    output logic                     round_done
);

    localparam int SLOT_W = $clog2(`HIST_RING_LEN);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`HIST_RING_LEN - 1);

    typedef enum logic [2:0] {
        S_IDLE,    // Wait for enable after reset.
        S_CLR_WR,  // Zero one ring slot.
        S_ROUND,   // Round start.
        S_SAMP_WR, // Newest sample into the ring.
        S_RD,      // Fetch one column value.
        S_JOB,     // Painter busy on that column.
        S_END      // Scroll and flag the round.
    } state_t;

    state_t                    state_q;
    logic [SLOT_W-1:0]         slot_q;   // Clear index, then read slot.
    logic [SLOT_W-1:0]         start_q;  // Oldest slot, scroll offset.
    logic [SLOT_W-1:0]         col_q;    // Plot column in this round.
    logic [`HIST_ADDR_W-1:0]   row_q;    // Row start of that column.
    logic [`HIST_DATA_W-1:0]   sample_q; // Last latched count.
    logic [7:0]                bar_h_q;  // Clipped bar height.
    logic [SLOT_W-1:0]         samp_slot;

    // Ring index plus one, wrapping at the ring length.
    function automatic logic [SLOT_W-1:0] slot_inc(input logic [SLOT_W-1:0] s);
        return (s == LAST_SLOT) ? '0 : s + 1'b1;
    endfunction

    function automatic logic [`HIST_ADDR_W-1:0] ring_addr(input logic [SLOT_W-1:0] s);
        return `HIST_ADDR_W'(`HIST_RING_BASE) + `HIST_ADDR_W'(s);
    endfunction

    // Counts above the plot height draw a full bar.
    function automatic logic [7:0] clip_height(input logic [`HIST_DATA_W-1:0] v);
        return (v > `HIST_DATA_W'(`HIST_PLOT_H)) ? 8'(`HIST_PLOT_H) : v[7:0];
    endfunction

    // New sample goes just behind the oldest one.
    assign samp_slot = (start_q == '0) ? LAST_SLOT : start_q - 1'b1;

    assign job.row_addr = row_q; // Stable while job_valid is high.
    assign job.height   = bar_h_q;

    ////////////////////////////////////////////////////////////////////////////
    // Round FSM.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= S_IDLE;
            wr_req     <= 1'b0;
            rd_req     <= 1'b0;
            job_valid  <= 1'b0;
            round_done <= 1'b0;
            slot_q     <= '0;
            start_q    <= '0;
            col_q      <= '0;
            row_q      <= `HIST_ADDR_W'(`HIST_PLOT_Y0);
            sample_q   <= '0;
        end else begin
            round_done <= 1'b0; // Single-cycle pulse.
            if (sample_valid) begin
                sample_q <= sample_count; // Older unwritten samples are lost.
            end
            case (state_q)
                S_IDLE: begin
                    if (en) begin
                        slot_q  <= '0;
                        state_q <= S_CLR_WR;
                    end
                end
                S_CLR_WR: begin
                    if (wr_done) begin
                        wr_req <= 1'b0; // Gap cycle before the next slot.
                        if (slot_q == LAST_SLOT) begin
                            state_q <= S_ROUND;
                        end else begin
                            slot_q <= slot_q + 1'b1;
                        end
                    end else begin
                        wr_req <= 1'b1;
                    end
                end
                S_ROUND: begin
                    if (en) begin
                        slot_q  <= start_q; // Column 0 shows the oldest slot.
                        col_q   <= '0;
                        row_q   <= `HIST_ADDR_W'(`HIST_PLOT_Y0);
                        state_q <= S_SAMP_WR;
                    end
                end
                S_SAMP_WR: begin
                    if (wr_done) begin
                        wr_req  <= 1'b0;
                        state_q <= S_RD;
                    end else begin
                        wr_req <= 1'b1;
                    end
                end
                S_RD: begin
                    if (rd_done) begin
                        rd_req  <= 1'b0;
                        state_q <= S_JOB;
                    end else begin
                        rd_req <= 1'b1;
                    end
                end
                S_JOB: begin
                    if (job_done) begin
                        job_valid <= 1'b0;
                        slot_q    <= slot_inc(slot_q);
                        col_q     <= col_q + 1'b1;
                        row_q     <= row_q + `HIST_ADDR_W'(`HIST_LINE_PITCH);
                        state_q   <= (col_q == LAST_SLOT) ? S_END : S_RD;
                    end else begin
                        job_valid <= 1'b1;
                    end
                end
                S_END: begin
                    round_done <= 1'b1;
                    start_q    <= slot_inc(start_q); // Graph moves one column left.
                    state_q    <= S_ROUND;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Command payload, loaded on the cycle req rises.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state_q == S_CLR_WR && !wr_req) begin
            wr_cmd.addr <= ring_addr(slot_q);
            wr_cmd.data <= '0;
        end else if (state_q == S_SAMP_WR && !wr_req) begin
            wr_cmd.addr <= ring_addr(samp_slot);
            wr_cmd.data <= sample_q; // Frozen for the whole access.
        end
        if (state_q == S_RD && !rd_req) begin
            rd_cmd.addr <= ring_addr(slot_q);
        end
        if (state_q == S_RD && rd_done) begin
            bar_h_q <= clip_height(rd_data);
        end
    end

endmodule

//--- hist_mem_arbiter.sv
module hist_mem_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    // Sequencer side.
    input  logic                seq_wr_req,
    input  hist_pkg::mem_wr_t   seq_wr_cmd,
    output logic                seq_wr_done,
    input  logic                seq_rd_req,
    input  hist_pkg::mem_rd_t   seq_rd_cmd,
    output logic                seq_rd_done,
    // Painter side.
    input  logic                pnt_wr_req,
    input  hist_pkg::mem_wr_t   pnt_wr_cmd,
    output logic                pnt_wr_done,
    // Memory side.
    output logic                wr_req,
    output hist_pkg::mem_wr_t   wr_cmd,
    input  logic                wr_done,
    output logic                rd_req,
    output hist_pkg::mem_rd_t   rd_cmd,
    input  logic                rd_done
);

    logic busy_q;      // Write access open.
    logic grant_pnt_q; // Owner of the open access.
    logic sel_pnt;     // Painter selected this cycle.

    ////////////////////////////////////////////////////////////////////////////
    // Write side.
    ////////////////////////////////////////////////////////////////////////////

    // Locked owner while busy. Otherwise the sequencer has priority.
    assign sel_pnt = busy_q ? grant_pnt_q : !seq_wr_req;

    assign wr_req = busy_q ? (grant_pnt_q ? pnt_wr_req : seq_wr_req)
                           : (seq_wr_req | pnt_wr_req);
    assign wr_cmd = sel_pnt ? pnt_wr_cmd : seq_wr_cmd;

    assign seq_wr_done = wr_done & !sel_pnt; // Only the owner sees done.
    assign pnt_wr_done = wr_done & sel_pnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q      <= 1'b0;
            grant_pnt_q <= 1'b0;
        end else if (wr_done) begin
            busy_q <= 1'b0; // Access closed and free for either side.
        end else if (!busy_q && wr_req) begin
            busy_q      <= 1'b1;
            grant_pnt_q <= sel_pnt;
        end
    end

    // Reads come from the sequencer alone.
    assign rd_req      = seq_rd_req;
    assign rd_cmd      = seq_rd_cmd;
    assign seq_rd_done = rd_done;

endmodule

//--- hist_pkg.sv
`include "hist_settings.svh"

package hist_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Memory port commands.
    ////////////////////////////////////////////////////////////////////////////

    // One write on the shared port.
    // Held stable from req until done.
    typedef struct packed {
        logic [`HIST_ADDR_W-1:0] addr; // Word address.
        logic [`HIST_DATA_W-1:0] data; // Pixel colour or count.
    } mem_wr_t;

    // One read on the shared port.
    // Data comes back with rd_done.
    typedef struct packed {
        logic [`HIST_ADDR_W-1:0] addr; // Ring slot address.
    } mem_rd_t;

    ////////////////////////////////////////////////////////////////////////////
    // Painter job.
    ////////////////////////////////////////////////////////////////////////////

    // One plot column, handed from sequencer to painter.
    // Height is already clipped to the plot height,
    // so 8 bits cover 0 to 220.
    typedef struct packed {
        logic [`HIST_ADDR_W-1:0] row_addr; // First word of the row.
        logic [7:0]              height; // Bar height in pixels.
    } column_job_t;

    // Word layout on the bus, MSB first.
    //   mem_wr_t     : addr[39:16], data[15:0].
    //   mem_rd_t     : addr[23:0].
    //   column_job_t : row_addr[31:8], height[7:0].
    // The testbench memory model and the bound
    // properties decode the same structs.

endpackage

//--- hist_scope_props.sv
`include "hist_settings.svh"

module hist_scope_props (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    sample_valid,
    input logic [`HIST_DATA_W-1:0] sample_count,
    input logic                    rd_req,
    input hist_pkg::mem_rd_t       rd_cmd,
    input logic                    rd_done,
    input logic [`HIST_DATA_W-1:0] rd_data,
    input logic                    wr_req,
    input hist_pkg::mem_wr_t       wr_cmd,
    input logic                    wr_done,
    input logic                    round_done
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LEN  = `HIST_RING_LEN;
    localparam int BASE = `HIST_RING_BASE;

    int fail_cnt = 0; // Watched by the testbench top.
    int mode;         // 0 ring clear, 1 sample write, 2 columns.
    int clr_n;        // Clear writes done.
    int k_slot;       // Round number mod ring length.
    int col;          // Reads done in this round.
    int pix_p;        // Next pixel offset or -1 after the column.
    logic [`HIST_DATA_W-1:0] v_q;      // Value of the current column.
    logic [`HIST_DATA_W-1:0] mirror;   // Last latched sample.
    logic [`HIST_DATA_W-1:0] mirror_d; // Value the sequencer loads into wr_cmd.
    int exp_rd, exp_samp, exp_pix, bar_h, addr_i;
    logic [`HIST_DATA_W-1:0] exp_color;

    // Ring region or a pixel inside the plot rectangle.
    function automatic bit in_map(input int a);
        int off;
        off = a - `HIST_PLOT_Y0;
        if (a >= BASE && a < BASE + LEN) return 1'b1;
        if (off < 0 || off >= LEN * `HIST_LINE_PITCH) return 1'b0;
        return (off % `HIST_LINE_PITCH) >= `HIST_PLOT_X0 &&
               (off % `HIST_LINE_PITCH) <= `HIST_PLOT_X0 + `HIST_PLOT_H;
    endfunction

    assign addr_i    = int'(wr_cmd.addr);
    assign exp_rd    = BASE + (k_slot + col) % LEN;          // Oldest slot first.
    assign exp_samp  = BASE + (k_slot + LEN - 1) % LEN;      // Just behind the start.
    assign exp_pix   = `HIST_PLOT_Y0 + (col - 1) * `HIST_LINE_PITCH + `HIST_PLOT_X0 + pix_p;
    assign bar_h     = (v_q > `HIST_PLOT_H) ? `HIST_PLOT_H : int'(v_q);
    assign exp_color = (pix_p > bar_h) ? `COLOR_BACKGROUND : `COLOR_BAR;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model of the round order.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode     <= 0;
            clr_n    <= 0;
            k_slot   <= 0;
            col      <= 0;
            pix_p    <= -1;
            v_q      <= '0;
            mirror   <= '0;
            mirror_d <= '0;
        end else begin
            if (sample_valid) mirror <= sample_count;
            mirror_d <= mirror;
            if (wr_done) begin
                case (mode)
                    0: begin
                        clr_n <= clr_n + 1;
                        if (clr_n == LEN - 1) mode <= 1; // Ring cleared.
                    end
                    1: mode <= 2;
                    default: pix_p <= pix_p - 1; // Walk down to baseline.
                endcase
            end
            if (rd_done) begin
                v_q   <= rd_data;
                pix_p <= `HIST_PLOT_H;
                col   <= col + 1;
            end
            if (round_done) begin
                mode   <= 1;
                col    <= 0;
                k_slot <= (k_slot == LEN - 1) ? 0 : k_slot + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Handshake.
    ////////////////////////////////////////////////////////////////////////////

    a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wr_req && !wr_done |=> wr_req && $stable(wr_cmd))
        else begin
            $error("ERR %0t wr_cmd exp %h got %h", $time, $past(wr_cmd), wr_cmd);
            fail_cnt++;
        end
    a_wr_drop: assert property (@(posedge clk) disable iff (!rst_n) wr_done |=> !wr_req)
        else begin
            $error("ERR %0t wr_req exp 0 got %b", $time, wr_req);
            fail_cnt++;
        end
    a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req && !rd_done |=> rd_req && $stable(rd_cmd))
        else begin
            $error("ERR %0t rd_cmd exp %h got %h", $time, $past(rd_cmd), rd_cmd);
            fail_cnt++;
        end
    a_rd_drop: assert property (@(posedge clk) disable iff (!rst_n) rd_done |=> !rd_req)
        else begin
            $error("ERR %0t rd_req exp 0 got %b", $time, rd_req);
            fail_cnt++;
        end

    ////////////////////////////////////////////////////////////////////////////
    // Ring and pixel map.
    ////////////////////////////////////////////////////////////////////////////

    a_clear: assert property (@(posedge clk) disable iff (!rst_n)
        wr_req && mode == 0 |-> addr_i == BASE + clr_n && wr_cmd.data == '0)
        else begin
            $error("ERR %0t wr_cmd exp %0d/0 got %0d/%h", $time, BASE + clr_n,
                   addr_i, wr_cmd.data);
            fail_cnt++;
        end
    a_no_early_rd: assert property (@(posedge clk) disable iff (!rst_n) rd_req |-> mode != 0)
        else begin
            $error("Read issued before the ring clear finished.");
            fail_cnt++;
        end
    a_samp_addr: assert property (@(posedge clk) disable iff (!rst_n)
        wr_req && mode == 1 |-> addr_i == exp_samp)
        else begin
            $error("ERR %0t wr_cmd.addr exp %0d got %0d", $time, exp_samp, addr_i);
            fail_cnt++;
        end
    a_samp_data: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wr_req) && mode == 1 |-> wr_cmd.data == mirror_d)
        else begin
            $error("ERR %0t wr_cmd.data exp %h got %h", $time, mirror_d, wr_cmd.data);
            fail_cnt++;
        end
    a_rd_addr: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req |-> int'(rd_cmd.addr) == exp_rd)
        else begin
            $error("ERR %0t rd_cmd.addr exp %0d got %0d", $time, exp_rd, rd_cmd.addr);
            fail_cnt++;
        end
    a_pix_count: assert property (@(posedge clk) disable iff (!rst_n) rd_done |-> pix_p == -1)
        else begin
            $error("Column ended with pixel writes missing.");
            fail_cnt++;
        end
    a_round_len: assert property (@(posedge clk) disable iff (!rst_n)
        round_done |-> pix_p == -1 && col == LEN)
        else begin
            $error("ERR %0t columns exp %0d got %0d", $time, LEN, col);
            fail_cnt++;
        end
    a_pix_addr: assert property (@(posedge clk) disable iff (!rst_n)
        wr_req && mode == 2 |-> pix_p >= 0 && addr_i == exp_pix)
        else begin
            $error("ERR %0t wr_cmd.addr exp %0d got %0d", $time, exp_pix, addr_i);
            fail_cnt++;
        end
    a_pix_color: assert property (@(posedge clk) disable iff (!rst_n)
        wr_req && mode == 2 |-> wr_cmd.data == exp_color)
        else begin
            $error("ERR %0t wr_cmd.data exp %h got %h", $time, exp_color, wr_cmd.data);
            fail_cnt++;
        end
    a_map: assert property (@(posedge clk) disable iff (!rst_n) wr_req |-> in_map(addr_i))
        else begin
            $error("Write outside ring and plot at address %0d.", addr_i);
            fail_cnt++;
        end

endmodule

bind hist_scope_top hist_scope_props props (.*);

//--- hist_scope_top.sv
`include "hist_settings.svh"

module hist_scope_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     en,
    input  logic                     sample_valid,
    input  logic [`HIST_DATA_W-1:0]  sample_count,
    // External memory, read side.
    output logic                     rd_req,
    output hist_pkg::mem_rd_t        rd_cmd,
    input  logic                     rd_done,
    input  logic [`HIST_DATA_W-1:0]  rd_data,
    // External memory, write side.
    output logic                     wr_req,
    output hist_pkg::mem_wr_t        wr_cmd,
    input  logic                     wr_done,
    output logic                     round_done
);

    logic                   seq_wr_req, seq_wr_done;
    hist_pkg::mem_wr_t      seq_wr_cmd;
    logic                   seq_rd_req, seq_rd_done;
    hist_pkg::mem_rd_t      seq_rd_cmd;
    logic                   pnt_wr_req, pnt_wr_done;
    hist_pkg::mem_wr_t      pnt_wr_cmd;
    logic                   job_valid, job_done;
    hist_pkg::column_job_t  job;

    // Ring, scroll and column order.
    hist_frame_seq u_seq (
        .clk, .rst_n, .en, .sample_valid, .sample_count,
        .wr_req(seq_wr_req), .wr_cmd(seq_wr_cmd), .wr_done(seq_wr_done),
        .rd_req(seq_rd_req), .rd_cmd(seq_rd_cmd), .rd_done(seq_rd_done),
        .rd_data, .job_valid, .job, .job_done, .round_done
    );

    // One column into pixel writes.
    hist_column_painter u_pnt (
        .clk, .rst_n, .job_valid, .job, .job_done,
        .wr_req(pnt_wr_req), .wr_cmd(pnt_wr_cmd), .wr_done(pnt_wr_done)
    );

    // Both onto the single memory port.
    hist_mem_arbiter u_arb (
        .clk, .rst_n,
        .seq_wr_req, .seq_wr_cmd, .seq_wr_done, .seq_rd_req, .seq_rd_cmd, .seq_rd_done,
        .pnt_wr_req, .pnt_wr_cmd, .pnt_wr_done,
        .wr_req, .wr_cmd, .wr_done, .rd_req, .rd_cmd, .rd_done
    );

endmodule

//--- hist_settings.svh
`ifndef HIST_SETTINGS_SVH
`define HIST_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Memory port.
////////////////////////////////////////////////////////////////////////////

`define HIST_ADDR_W 24 // Bank, row and column bits of the SDRAM.
`define HIST_DATA_W 16 // One RGB565 pixel or one pulse count.

////////////////////////////////////////////////////////////////////////////
// Memory map.
////////////////////////////////////////////////////////////////////////////

// LCD frame buffer sits at 0 and fills 480 x 800 words.
`define HIST_RING_BASE 384000 // History ring follows the frame buffer.
`define HIST_RING_LEN 600 // One slot per plot column.

////////////////////////////////////////////////////////////////////////////
// Plot geometry.
////////////////////////////////////////////////////////////////////////////

// Panel is scanned rotated. A plot column is one frame-buffer row.
`define HIST_LINE_PITCH 480 // Words per frame-buffer row.
`define HIST_PLOT_Y0 9600 // Row 20 holds the first plot column.
`define HIST_PLOT_X0 15 // Baseline offset inside a row.
`define HIST_PLOT_H 220 // Tallest bar and clip level.

// RGB565 colours.
`define COLOR_BACKGROUND 16'h0000 // Black.
`define COLOR_BAR 16'hF81F // Pink.

`endif

//--- src.f
+incdir+.
hist_pkg.sv
hist_frame_seq.sv
hist_column_painter.sv
hist_mem_arbiter.sv
hist_scope_top.sv
hist_scope_props.sv
tb_hist_scope.sv

//--- tb_hist_scope.sv
`include "hist_settings.svh"

module tb_hist_scope;
    timeunit 1ns;
    timeprecision 1ps;

    // Three rounds of 600 columns with 222 accesses of up to 6 cycles.
    localparam longint WATCHDOG_NS = (3 * 600 * 222 * 6 + 5000) * 20;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    en;
    logic                    sample_valid;
    logic [`HIST_DATA_W-1:0] sample_count;
    logic                    rd_req, rd_done, wr_req, wr_done, round_done;
    logic [`HIST_DATA_W-1:0] rd_data;
    hist_pkg::mem_rd_t       rd_cmd;
    hist_pkg::mem_wr_t       wr_cmd;

    logic [`HIST_DATA_W-1:0] mem [int]; // Sparse SDRAM model.
    int seed = 17;
    int wr_cnt;  // Cycles left on the open write or -1 when idle.
    int rd_cnt;
    int gap;     // Cycles to the next sample pulse.
    int rounds;

    hist_scope_top dut (
        .clk, .rst_n, .en, .sample_valid, .sample_count,
        .rd_req, .rd_cmd, .rd_done, .rd_data,
        .wr_req, .wr_cmd, .wr_done, .round_done
    );

    // Unwritten words read back as a mix of all address bits.
    function automatic logic [`HIST_DATA_W-1:0] fill_word(input logic [`HIST_ADDR_W-1:0] a);
        return a[15:0] ^ {8'h00, a[23:16]};
    endfunction

    always #10 clk = ~clk;

    initial begin
        rst_n        = 1'b0;
        en           = 1'b0;
        sample_valid = 1'b0;
        sample_count = '0;
        rd_done      = 1'b0;
        wr_done      = 1'b0;
        rd_data      = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory model and sample source.
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst_n) begin
            wr_cnt = -1;
            rd_cnt = -1;
            gap    = 300;
        end else begin
            en <= 1'b1;
            // Write side answers in 1 to 4 cycles.
            if (wr_done) begin
                wr_done <= 1'b0; // Req is still high on this edge.
            end else if (wr_req) begin
                if (wr_cnt < 0) begin
                    wr_cnt = $unsigned($random(seed)) % 4;
                end
                if (wr_cnt == 0) begin
                    mem[int'(wr_cmd.addr)] = wr_cmd.data;
                    wr_done <= 1'b1;
                    wr_cnt = -1;
                end else begin
                    wr_cnt = wr_cnt - 1;
                end
            end
            // Read side.
            if (rd_done) begin
                rd_done <= 1'b0;
            end else if (rd_req) begin
                if (rd_cnt < 0) begin
                    rd_cnt = $unsigned($random(seed)) % 4;
                end
                if (rd_cnt == 0) begin
                    rd_data <= mem.exists(int'(rd_cmd.addr)) ? mem[int'(rd_cmd.addr)]
                                                             : fill_word(rd_cmd.addr);
                    rd_done <= 1'b1;
                    rd_cnt = -1;
                end else begin
                    rd_cnt = rd_cnt - 1;
                end
            end
            // Pulse counter with counts past the plot height.
            sample_valid <= (gap == 0);
            if (gap == 0) begin
                sample_count <= $unsigned($random(seed)) % 320;
                gap = 200 + $unsigned($random(seed)) % 300;
            end else begin
                gap = gap - 1;
            end
        end
    end

    // First failed assertion ends the run.
    always @(posedge clk) begin
        if (dut.props.fail_cnt != 0) begin
            $display("Test FAILED");
            $fatal(1, "An assertion on the memory port failed.");
        end
    end

    initial begin
        rounds = 0;
        while (rounds < 3) begin
            @(posedge clk);
            if (round_done) rounds++;
        end
        @(posedge clk);
        if (dut.props.fail_cnt == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Test FAILED");
            $fatal(1, "Assertions failed during the run.");
        end
    end

    // Watchdog.
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: three redraw rounds did not finish in time.");
        $display("Test FAILED");
        $fatal(1, "Watchdog expired.");
    end

endmodule
